// ==== logic/ipv4_pkg.sv ====
// --------------------------------------------------
// Ethernet and IPv4 header field types and constants
// --------------------------------------------------

package ipv4_pkg;

    // --------------------------------------------------
    // Header layouts
    // --------------------------------------------------

    typedef struct packed {
        logic [47:0] dest_mac;
        logic [47:0] src_mac;
        logic [15:0] eth_type;
    } eth_hdr_t;

    // Version and IHL implied by the fixed IHL of 5
    typedef struct packed {
        logic [5:0]  dscp;
        logic [1:0]  ecn;
        logic [15:0] length;               // Total length in bytes
        logic [15:0] identification;
        logic [2:0]  flags;                // Reserved, DF, MF
        logic [12:0] fragment_offset;
        logic [7:0]  ttl;
        logic [7:0]  protocol;
        logic [15:0] hdr_chksum;           // As carried on the wire
        logic [31:0] source_ip;
        logic [31:0] dest_ip;
    } ipv4_hdr_t;

    typedef struct packed {
        eth_hdr_t  eth;
        ipv4_hdr_t ip;
    } pkt_hdr_t;

    // --------------------------------------------------
    // Field constants
    // --------------------------------------------------

    localparam logic [15:0] ETHERTYPE_IPV4  = 16'h0800;
    localparam logic [7:0]  IPV4_VER_IHL    = 8'h45;   // Version 4, 5 words
    localparam logic [15:0] IPV4_MIN_LENGTH = 16'd20;

endpackage

// ==== logic/hdr_check_pkg.sv ====
// --------------------------------------------------
// Verdict, result and flag types of the header checker
// --------------------------------------------------

package hdr_check_pkg;

    // Register stages inside the checksum generator
    localparam int unsigned CHKSUM_LATENCY = 2;

    typedef struct packed {
        logic not_ipv4;
        logic bad_length;
        logic ttl_expired;
        logic bad_flags;
    } field_flags_t;

    // --------------------------------------------------
    // Verdict codes
    // --------------------------------------------------

    typedef enum logic [2:0] {
        VERDICT_OK           = 3'd0,
        VERDICT_NOT_IPV4     = 3'd1,
        VERDICT_BAD_CHECKSUM = 3'd2,
        VERDICT_BAD_LENGTH   = 3'd3,
        VERDICT_TTL_EXPIRED  = 3'd4,
        VERDICT_BAD_FLAGS    = 3'd5
    } verdict_e;

    typedef struct packed {
        logic        valid;
        verdict_e    verdict;
        logic [15:0] identification;
        logic [15:0] computed_chksum;      // Reported even on mismatch
    } check_result_t;

endpackage

// ==== logic/ipv4_checksum_gen.sv ====
// --------------------------------------------------
// IPv4 header checksum generator with two register stages
// --------------------------------------------------

`timescale 1ns/1ns

module ipv4_checksum_gen (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               req,
    input  ipv4_pkg::pkt_hdr_t hdr,
    output logic               valid,
    output logic [15:0]        chksum
);

    import ipv4_pkg::*;

    logic [15:0] words [10];
    logic [18:0] part_a;                   // Five words need 3 carry bits
    logic [18:0] part_b;

    logic        stage1_valid;
    logic [18:0] part_a_q;
    logic [18:0] part_b_q;

    logic [19:0] total;
    logic [16:0] fold1;
    logic [15:0] fold2;

    // --------------------------------------------------
    // Header words and partial sums
    // --------------------------------------------------

    always_comb begin
        words[0] = {IPV4_VER_IHL, hdr.ip.dscp, hdr.ip.ecn};
        words[1] = hdr.ip.length;
        words[2] = hdr.ip.identification;
        words[3] = {hdr.ip.flags, hdr.ip.fragment_offset};
        words[4] = {hdr.ip.ttl, hdr.ip.protocol};
        words[5] = 16'h0000;               // Checksum field counts as zero
        words[6] = hdr.ip.source_ip[31:16];
        words[7] = hdr.ip.source_ip[15:0];
        words[8] = hdr.ip.dest_ip[31:16];
        words[9] = hdr.ip.dest_ip[15:0];
    end

    always_comb begin
        part_a = '0;
        part_b = '0;
        for (int i = 0; i < 5; i++) begin
            part_a = part_a + 19'(words[i]);
            part_b = part_b + 19'(words[i + 5]);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            stage1_valid <= 1'b0;
        end else begin
            stage1_valid <= req;
        end
        part_a_q <= part_a;
        part_b_q <= part_b;
    end

    // --------------------------------------------------
    // End-around carry and inversion
    // --------------------------------------------------

    assign total = 20'(part_a_q) + 20'(part_b_q);
    assign fold1 = 17'(total[15:0]) + 17'(total[19:16]);
    assign fold2 = fold1[15:0] + 16'(fold1[16]);   // Second fold cannot carry

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid <= 1'b0;
        end else begin
            valid <= stage1_valid;
        end
        chksum <= ~fold2;
    end

endmodule

// ==== logic/ipv4_checksum_verify.sv ====
// --------------------------------------------------
// Compares the received IPv4 checksum with the computed one
// --------------------------------------------------

`timescale 1ns/1ns

module ipv4_checksum_verify (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               req,
    input  ipv4_pkg::pkt_hdr_t hdr,
    output logic               output_valid,
    output logic               chksum_valid,
    output logic [15:0]        computed_chksum
);

    import hdr_check_pkg::*;

    logic        gen_valid;
    logic [15:0] gen_chksum;

    logic [CHKSUM_LATENCY-1:0] req_d;
    logic [15:0]               rx_chksum_d [CHKSUM_LATENCY];

    ipv4_checksum_gen i_chksum_gen (
        .clk    (clk),
        .rst_n  (rst_n),
        .req    (req),
        .hdr    (hdr),
        .valid  (gen_valid),
        .chksum (gen_chksum)
    );

    // --------------------------------------------------
    // Delay line matching the generator depth
    // --------------------------------------------------

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            req_d <= '0;
        end else begin
            req_d[0] <= req;
            for (int i = 1; i < CHKSUM_LATENCY; i++) begin
                req_d[i] <= req_d[i - 1];
            end
        end
        rx_chksum_d[0] <= hdr.ip.hdr_chksum;
        for (int i = 1; i < CHKSUM_LATENCY; i++) begin
            rx_chksum_d[i] <= rx_chksum_d[i - 1];
        end
    end

    // Compare stage
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            output_valid <= 1'b0;
            chksum_valid <= 1'b0;
        end else begin
            output_valid <= req_d[CHKSUM_LATENCY-1];
            chksum_valid <= gen_valid &&
                            (gen_chksum == rx_chksum_d[CHKSUM_LATENCY-1]);
        end
        computed_chksum <= gen_chksum;     // Kept for reporting
    end

endmodule

// ==== logic/ipv4_field_check.sv ====
// --------------------------------------------------
// Ethertype, length, TTL and reserved flag checks
// --------------------------------------------------

`timescale 1ns/1ns

module ipv4_field_check (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        req,
    input  ipv4_pkg::pkt_hdr_t          hdr,
    output logic                        flags_valid,
    output hdr_check_pkg::field_flags_t flags,
    output logic [15:0]                 identification
);

    import ipv4_pkg::*;
    import hdr_check_pkg::*;

    // Same depth as the checksum verifier
    localparam int unsigned STAGES = CHKSUM_LATENCY + 1;

    field_flags_t check_now;

    logic [STAGES-1:0] valid_q;
    field_flags_t      flags_q [STAGES];
    logic [15:0]       id_q    [STAGES];

    // --------------------------------------------------
    // Field rules in the request cycle
    // --------------------------------------------------

    always_comb begin
        check_now.not_ipv4    = (hdr.eth.eth_type != ETHERTYPE_IPV4);
        check_now.bad_length  = (hdr.ip.length < IPV4_MIN_LENGTH);
        check_now.ttl_expired = (hdr.ip.ttl == 8'd0);
        check_now.bad_flags   = hdr.ip.flags[2];   // Reserved bit
    end

    // --------------------------------------------------
    // Alignment pipeline
    // --------------------------------------------------

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else begin
            valid_q[0] <= req;
            for (int i = 1; i < STAGES; i++) begin
                valid_q[i] <= valid_q[i - 1];
            end
        end
        flags_q[0] <= check_now;
        id_q[0]    <= hdr.ip.identification;
        for (int i = 1; i < STAGES; i++) begin
            flags_q[i] <= flags_q[i - 1];
            id_q[i]    <= id_q[i - 1];
        end
    end

    assign flags_valid    = valid_q[STAGES-1];
    assign flags          = flags_q[STAGES-1];
    assign identification = id_q[STAGES-1];

endmodule

// ==== logic/hdr_verdict_stats.sv ====
// --------------------------------------------------
// Prioritized verdict and saturating accept/drop counters
// --------------------------------------------------

`timescale 1ns/1ns

module hdr_verdict_stats #(
    parameter int unsigned STAT_WIDTH = 16
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         stats_clear,
    input  logic                         flags_valid,
    input  hdr_check_pkg::field_flags_t  flags,
    input  logic [15:0]                  identification,
    input  logic                         chksum_valid,
    input  logic [15:0]                  computed_chksum,
    output hdr_check_pkg::check_result_t result,
    output logic [STAT_WIDTH-1:0]        accept_count,
    output logic [STAT_WIDTH-1:0]        drop_count
);

    import hdr_check_pkg::*;

    verdict_e    verdict;
    logic        valid_q;
    verdict_e    verdict_q;
    logic [15:0] id_q;
    logic [15:0] chksum_q;

    // First failing rule wins
    always_comb begin
        if (flags.not_ipv4)         verdict = VERDICT_NOT_IPV4;
        else if (!chksum_valid)     verdict = VERDICT_BAD_CHECKSUM;
        else if (flags.bad_length)  verdict = VERDICT_BAD_LENGTH;
        else if (flags.ttl_expired) verdict = VERDICT_TTL_EXPIRED;
        else if (flags.bad_flags)   verdict = VERDICT_BAD_FLAGS;
        else                        verdict = VERDICT_OK;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= flags_valid;        // Verifier valid runs in step
        end
        verdict_q <= verdict;
        id_q      <= identification;
        chksum_q  <= computed_chksum;
    end

    assign result = '{valid: valid_q, verdict: verdict_q,
                      identification: id_q, computed_chksum: chksum_q};

    // --------------------------------------------------
    // Statistics
    // --------------------------------------------------

    always_ff @(posedge clk) begin
        if (!rst_n || stats_clear) begin   // Clear beats a landing result
            accept_count <= '0;
            drop_count   <= '0;
        end else if (valid_q) begin
            if (verdict_q == VERDICT_OK) begin
                if (accept_count != '1) accept_count <= accept_count + 1'b1;
            end else begin
                if (drop_count != '1) drop_count <= drop_count + 1'b1;
            end
        end
    end

endmodule

// ==== logic/ipv4_header_check_top.sv ====
// --------------------------------------------------
// IPv4 header checker top level
// --------------------------------------------------

`timescale 1ns/1ns

module ipv4_header_check_top #(
    parameter int unsigned STAT_WIDTH = 16
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         req,
    input  logic                         stats_clear,
    input  ipv4_pkg::pkt_hdr_t           hdr,
    output hdr_check_pkg::check_result_t result,
    output logic [STAT_WIDTH-1:0]        accept_count,
    output logic [STAT_WIDTH-1:0]        drop_count
);

    logic                        chksum_valid;
    logic [15:0]                 computed_chksum;
    logic                        flags_valid;
    hdr_check_pkg::field_flags_t flags;
    logic [15:0]                 identification;

    // --------------------------------------------------
    // Checkers three cycles deep
    // --------------------------------------------------

    ipv4_checksum_verify i_chksum_verify (
        .clk             (clk),
        .rst_n           (rst_n),
        .req             (req),
        .hdr             (hdr),
        .output_valid    (),               // Same timing as flags_valid
        .chksum_valid    (chksum_valid),
        .computed_chksum (computed_chksum)
    );

    ipv4_field_check i_field_check (
        .clk            (clk),
        .rst_n          (rst_n),
        .req            (req),
        .hdr            (hdr),
        .flags_valid    (flags_valid),
        .flags          (flags),
        .identification (identification)
    );

    hdr_verdict_stats #(
        .STAT_WIDTH (STAT_WIDTH)
    ) i_verdict_stats (
        .clk             (clk),
        .rst_n           (rst_n),
        .stats_clear     (stats_clear),
        .flags_valid     (flags_valid),
        .flags           (flags),
        .identification  (identification),
        .chksum_valid    (chksum_valid),
        .computed_chksum (computed_chksum),
        .result          (result),
        .accept_count    (accept_count),
        .drop_count      (drop_count)
    );

endmodule

// ==== tb/tb_ipv4_header_check.sv ====
// --------------------------------------------------
// Testbench for the IPv4 header checker
// --------------------------------------------------

`timescale 1ns/1ns

module tb_ipv4_header_check;

    import ipv4_pkg::*;
    import hdr_check_pkg::*;

    localparam int unsigned STAT_WIDTH = 4;    // Small enough to saturate

    logic                  clk;
    logic                  rst_n;
    logic                  req;
    logic                  stats_clear;
    pkt_hdr_t              hdr;
    check_result_t         result;
    logic [STAT_WIDTH-1:0] accept_count;
    logic [STAT_WIDTH-1:0] drop_count;

    check_result_t exp_q [$];                  // Expected results in request order
    string         name_q [$];
    int            errors = 0;
    int            checks = 0;

    ipv4_header_check_top #(
        .STAT_WIDTH (STAT_WIDTH)
    ) i_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .req          (req),
        .stats_clear  (stats_clear),
        .hdr          (hdr),
        .result       (result),
        .accept_count (accept_count),
        .drop_count   (drop_count)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // --------------------------------------------------
    // Reference model
    // --------------------------------------------------

    function automatic logic [15:0] header_checksum(input pkt_hdr_t h);
        logic [31:0] sum;
        sum = 32'({8'h45, h.ip.dscp, h.ip.ecn}) + 32'(h.ip.length)
            + 32'(h.ip.identification) + 32'({h.ip.flags, h.ip.fragment_offset})
            + 32'({h.ip.ttl, h.ip.protocol}) + 32'(h.ip.source_ip[31:16])
            + 32'(h.ip.source_ip[15:0]) + 32'(h.ip.dest_ip[31:16])
            + 32'(h.ip.dest_ip[15:0]);             // Checksum word counts as zero
        while (sum[31:16] != 16'd0) begin
            sum = 32'(sum[15:0]) + 32'(sum[31:16]);
        end
        return ~sum[15:0];
    endfunction

    function automatic check_result_t expected_result(input pkt_hdr_t h);
        check_result_t e;
        logic [15:0]   c;
        c = header_checksum(h);
        e.valid           = 1'b1;
        e.identification  = h.ip.identification;
        e.computed_chksum = c;
        if (h.eth.eth_type != 16'h0800)    e.verdict = VERDICT_NOT_IPV4;
        else if (h.ip.hdr_chksum != c)     e.verdict = VERDICT_BAD_CHECKSUM;
        else if (h.ip.length < 16'd20)     e.verdict = VERDICT_BAD_LENGTH;
        else if (h.ip.ttl == 8'd0)         e.verdict = VERDICT_TTL_EXPIRED;
        else if (h.ip.flags[2])            e.verdict = VERDICT_BAD_FLAGS;
        else                               e.verdict = VERDICT_OK;
        return e;
    endfunction

    function automatic pkt_hdr_t random_header();
        pkt_hdr_t h;
        h.eth.dest_mac          = {16'($urandom), $urandom};
        h.eth.src_mac           = {16'($urandom), $urandom};
        h.eth.eth_type          = 16'h0800;
        h.ip.dscp               = 6'($urandom);
        h.ip.ecn                = 2'($urandom);
        h.ip.length             = 16'(20 + $urandom_range(1480));
        h.ip.identification     = 16'($urandom);
        h.ip.flags              = {1'b0, 2'($urandom)};
        h.ip.fragment_offset    = 13'($urandom);
        h.ip.ttl                = 8'($urandom_range(255, 1));
        h.ip.protocol           = 8'($urandom);
        h.ip.source_ip          = $urandom;
        h.ip.dest_ip            = $urandom;
        h.ip.hdr_chksum         = header_checksum(h);
        return h;
    endfunction

    // --------------------------------------------------
    // Checks and stimulus helpers
    // --------------------------------------------------

    task automatic end_run(input bit timed_out);
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0 && !timed_out) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    endtask

    task automatic check_value(input string name, input string what,
                               input logic [31:0] expected, input logic [31:0] actual);
        checks++;
        assert (actual === expected) else begin
            errors++;
            $display("mismatch %s %s: expected %0h actual %0h", name, what, expected, actual);
        end
    endtask

    task automatic check_counts(input string name, input int acc, input int drop);
        check_value(name, "accept_count", acc, accept_count);
        check_value(name, "drop_count", drop, drop_count);
    endtask

    // Drives on a falling edge and returns one cycle later
    task automatic send(input pkt_hdr_t h, input string name);
        req = 1'b1;
        hdr = h;
        exp_q.push_back(expected_result(h));
        name_q.push_back(name);
        @(negedge clk);
        req = 1'b0;
    endtask

    task automatic wait_drain(input string name);
        int cycles;
        cycles = 0;
        while (exp_q.size() != 0 && cycles < 10) begin
            @(negedge clk);
            cycles++;
        end
        if (exp_q.size() != 0) begin
            $display("timeout: %s still waits for %0d results", name, exp_q.size());
            end_run(1'b1);
        end
    endtask

    // Compare each result with the oldest expected entry
    always @(negedge clk) begin
        check_result_t e;
        string         name;
        if (rst_n && result.valid === 1'b1) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("result arrived with no request outstanding");
            end else begin
                e    = exp_q.pop_front();
                name = name_q.pop_front();
                check_value(name, "verdict", e.verdict, result.verdict);
                check_value(name, "identification", e.identification, result.identification);
                check_value(name, "computed_chksum", e.computed_chksum,
                            result.computed_chksum);
            end
        end
    end

    // Latency of exactly 4 cycles in both directions
    assert property (@(posedge clk) disable iff (!rst_n) req |-> ##4 result.valid) else begin
        errors++;
        $display("result valid missing 4 cycles after a request");
    end

    assert property (@(posedge clk) disable iff (!rst_n) result.valid |-> $past(req, 4))
    else begin
        errors++;
        $display("result valid without a request 4 cycles earlier");
    end

    assert property (@(posedge clk) !rst_n |=> !result.valid) else begin
        errors++;
        $display("result valid high after a reset cycle");
    end

    // --------------------------------------------------
    // Test sequence
    // --------------------------------------------------

    initial begin
        pkt_hdr_t h;
        void'($urandom(32'ha781));
        rst_n       = 1'b0;
        req         = 1'b0;
        stats_clear = 1'b0;
        hdr         = '0;
        repeat (2) @(negedge clk);
        check_value("reset", "result valid", 0, result.valid);
        check_counts("reset", 0, 0);
        rst_n = 1'b1;
        @(negedge clk);
        check_value("after reset", "result valid", 0, result.valid);
        check_counts("after reset", 0, 0);

        h = random_header();
        send(h, "good header");
        wait_drain("good header");
        @(negedge clk);
        check_counts("good header", 1, 0);

        h = random_header();
        h.ip.hdr_chksum ^= 16'h0010;               // One flipped bit
        send(h, "bad checksum");
        h = random_header();
        h.eth.eth_type = 16'h86dd;
        h.ip.hdr_chksum = header_checksum(h);
        send(h, "not ipv4");
        h = random_header();
        h.ip.length = 16'd19;
        h.ip.hdr_chksum = header_checksum(h);
        send(h, "bad length");
        h = random_header();
        h.ip.ttl = 8'd0;
        h.ip.hdr_chksum = header_checksum(h);
        send(h, "ttl expired");
        h = random_header();
        h.ip.flags[2] = 1'b1;
        h.ip.hdr_chksum = header_checksum(h);
        send(h, "reserved flag");
        h = random_header();
        h.ip.length = 16'd19;                      // Stale checksum as well
        h.ip.ttl = 8'd0;
        send(h, "multi checksum");
        h.eth.eth_type = 16'h86dd;
        send(h, "multi not ipv4");
        h = random_header();
        h.ip.length = 16'd10;
        h.ip.flags[2] = 1'b1;
        h.ip.hdr_chksum = header_checksum(h);
        send(h, "multi length");
        wait_drain("field faults");

        for (int i = 0; i < 12; i++) begin
            h = random_header();
            if ($urandom_range(3) == 0) begin
                h.ip.ttl = 8'd0;
                h.ip.hdr_chksum = header_checksum(h);
            end
            send(h, "burst");
        end
        wait_drain("burst");

        // Drop count starts from zero so a wrap would show
        stats_clear = 1'b1;
        @(negedge clk);
        stats_clear = 1'b0;
        for (int i = 0; i < 18; i++) begin
            h = random_header();
            h.eth.eth_type = 16'h86dd;
            send(h, "drop saturation");
        end
        wait_drain("drop saturation");
        @(negedge clk);
        check_counts("drop saturation", 0, 15);

        // Clear lands on the edge that would count this result
        h = random_header();
        send(h, "clear wins");
        repeat (3) @(negedge clk);
        stats_clear = 1'b1;
        @(negedge clk);
        stats_clear = 1'b0;
        check_counts("clear wins", 0, 0);

        h = random_header();
        send(h, "after clear");
        wait_drain("after clear");
        @(negedge clk);
        check_counts("after clear", 1, 0);

        end_run(1'b0);
    end

endmodule

// ==== filelist.f ====
logic/ipv4_pkg.sv
logic/hdr_check_pkg.sv
logic/ipv4_checksum_gen.sv
logic/ipv4_checksum_verify.sv
logic/ipv4_field_check.sv
logic/hdr_verdict_stats.sv
logic/ipv4_header_check_top.sv
tb/tb_ipv4_header_check.sv
